// ==== files.f ====
+incdir+source
source/mipsPkg.sv
source/aluUnit.sv
source/regFile.sv
source/dataPath.sv
source/controlUnit.sv
source/mipsCpuBus.sv
verification/mipsCpuBusTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -f files.f --top-module mipsCpuBusTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== source/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit import mipsPkg::*; (
    input  word_t      opA,
    input  word_t      opB,
    input  logic [4:0] shamt,
    input  aluOp_e     op,
    output word_t      result,
    output logic       zero
);

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = ($signed(opA) < $signed(opB));
    assign ltUnsigned = (opA < opB);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = opA + opB;
            end
            ALU_SUB: begin
                result = opA - opB;
            end
            ALU_AND: begin
                result = opA & opB;
            end
            ALU_OR: begin
                result = opA | opB;
            end
            ALU_XOR: begin
                result = opA ^ opB;
            end
            ALU_SLT: begin
                result = {31'b0, ltSigned};
            end
            ALU_SLTU: begin
                result = {31'b0, ltUnsigned};
            end
            ALU_SLL: begin
                result = opB << shamt;     // shifts act on rt.
            end
            ALU_SRL: begin
                result = opB >> shamt;
            end
            ALU_LUI: begin
                result = {opB[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // operand equality, for BEQ and BNE.
    assign zero = (opA == opB);

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module controlUnit import mipsPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      waitRequest,
    input  instr_t    instr,
    input  logic      aluZero,
    input  word_t     jumpTarget,
    output cpuState_e state,
    output ctrl_t     ctrl,
    output logic      read,
    output logic      write,
    output logic      active
);

    cpuState_e stateNext;
    ctrl_t     dec;         // what the instruction needs, before state gating.
    logic      isJump;
    logic      branchTaken;

    // decode through the union views.
    always_comb begin
        dec           = '0;
        dec.pcSel     = PC_SEQ;
        dec.aluOp     = ALU_ADD;
        dec.aluBSrc   = B_IMM;
        dec.regDstSel = DST_RT;
        dec.wbSel     = WB_ALU;
        case (instr.iView.opcode)
            OP_RTYPE: begin
                dec.aluBSrc   = B_REG;
                dec.regDstSel = DST_RD;
                dec.regWrite  = 1'b1;
                case (instr.rView.funct)
                    F_ADDU: dec.aluOp = ALU_ADD;
                    F_SUBU: dec.aluOp = ALU_SUB;
                    F_AND:  dec.aluOp = ALU_AND;
                    F_OR:   dec.aluOp = ALU_OR;
                    F_XOR:  dec.aluOp = ALU_XOR;
                    F_SLT:  dec.aluOp = ALU_SLT;
                    F_SLTU: dec.aluOp = ALU_SLTU;
                    F_SLL:  dec.aluOp = ALU_SLL;
                    F_SRL:  dec.aluOp = ALU_SRL;
                    F_JR: begin
                        dec.regWrite = 1'b0;
                        dec.pcSel    = PC_JREG;
                    end
                    default: dec.regWrite = 1'b0;  // unknown funct runs as a nop.
                endcase
            end
            OP_ADDIU: begin
                dec.regWrite  = 1'b1;
                dec.extSigned = 1'b1;
            end
            OP_SLTI: begin
                dec.regWrite  = 1'b1;
                dec.extSigned = 1'b1;
                dec.aluOp     = ALU_SLT;
            end
            OP_SLTIU: begin
                dec.regWrite  = 1'b1;
                dec.extSigned = 1'b1;   // sign extended, then compared unsigned.
                dec.aluOp     = ALU_SLTU;
            end
            OP_ANDI: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = ALU_AND;
            end
            OP_ORI: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = ALU_OR;
            end
            OP_XORI: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = ALU_XOR;
            end
            OP_LUI: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = ALU_LUI;
            end
            OP_LW: begin
                dec.regWrite  = 1'b1;
                dec.extSigned = 1'b1;
                dec.wbSel     = WB_MEM;
                dec.memRead   = 1'b1;
            end
            OP_SW: begin
                dec.extSigned = 1'b1;
                dec.memWrite  = 1'b1;
            end
            OP_BEQ: begin
                dec.aluBSrc      = B_REG;
                dec.aluOp        = ALU_SUB;
                dec.takeBranchEq = 1'b1;
            end
            OP_BNE: begin
                dec.aluBSrc      = B_REG;
                dec.aluOp        = ALU_SUB;
                dec.takeBranchNe = 1'b1;
            end
            OP_J: dec.pcSel = PC_JUMP;
            OP_JAL: begin
                dec.pcSel     = PC_JUMP;
                dec.regWrite  = 1'b1;
                dec.regDstSel = DST_RA;
                dec.wbSel     = WB_PC4;
            end
            default: ;
        endcase
    end

    assign branchTaken = (dec.takeBranchEq && aluZero) || (dec.takeBranchNe && !aluZero);
    assign isJump      = (dec.pcSel == PC_JUMP) || (dec.pcSel == PC_JREG);

    // enables only in the state where each register may change.
    always_comb begin
        ctrl             = dec;
        ctrl.irLoad      = (state == FETCH);
        ctrl.pcLoad      = (state == EXEC2) ||
                           (state == EXEC1 && !(dec.memRead || dec.memWrite));
        ctrl.regWrite    = dec.regWrite &&
                           ((state == EXEC1 && !dec.memRead) || (state == EXEC2 && dec.memRead));
        ctrl.memRead     = (state == EXEC2) && dec.memRead;
        ctrl.memWrite    = (state == EXEC2) && dec.memWrite;
        ctrl.addrFromAlu = (state == EXEC2);
        if (branchTaken) begin
            ctrl.pcSel = PC_BRANCH;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            FETCH: begin
                if (!waitRequest) begin
                    stateNext = EXEC1;
                end
            end
            EXEC1: begin
                if (dec.memRead || dec.memWrite) begin
                    stateNext = EXEC2;
                end else if (isJump && jumpTarget == `HALT_ADDR) begin
                    stateNext = HALTED;
                end else begin
                    stateNext = FETCH;
                end
            end
            EXEC2: begin
                if (!waitRequest) begin
                    stateNext = FETCH;
                end
            end
            default: stateNext = HALTED;   // no way out but reset.
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= FETCH;
        end else begin
            state <= stateNext;
        end
    end

    // no strobe while reset is held.
    assign read   = arstN && ((state == FETCH) || ctrl.memRead);
    assign write  = ctrl.memWrite;
    assign active = (state != HALTED);

endmodule

// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// first instruction fetch after reset.
`define RESET_VECTOR 32'hBFC00000

// a jump to this address stops the CPU.
`define HALT_ADDR 32'h00000000

// general purpose registers, $0 included.
`define REG_COUNT 32

// the bus only moves whole words.
`define BYTE_ENABLE_ALL 4'b1111

// $ra, written by JAL.
`define RA_INDEX 5'd31

`endif

// ==== source/dataPath.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module dataPath import mipsPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       waitRequest,
    input  word_t      readData,
    input  cpuState_e  state,
    input  ctrl_t      ctrl,
    output instr_t     instr,
    output logic       aluZero,
    output word_t      jumpTarget,
    output word_t      registerV0,
    output word_t      address,
    output word_t      writeData,
    output logic [3:0] byteEnable
);

    word_t      pc;
    word_t      pcPlus4;
    word_t      branchTarget;
    word_t      pcNext;
    word_t      rsValue;
    word_t      rtValue;
    word_t      immExt;
    word_t      aluB;
    word_t      aluResult;
    word_t      wbValue;
    logic [4:0] wbAddr;
    logic       hold;       // bus transfer still pending.

    assign hold = waitRequest && (state == FETCH || state == EXEC2);

    // pc still points at the current instruction during EXEC.
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{instr.iView.imm16[15]}}, instr.iView.imm16, 2'b00};
    assign immExt       = ctrl.extSigned ? {{16{instr.iView.imm16[15]}}, instr.iView.imm16}
                                         : {16'h0000, instr.iView.imm16};

    assign jumpTarget = (ctrl.pcSel == PC_JREG) ? rsValue
                                                : {pcPlus4[31:28], instr.jView.target26, 2'b00};

    always_comb begin
        case (ctrl.pcSel)
            PC_BRANCH: pcNext = branchTarget;
            PC_JUMP,
            PC_JREG:   pcNext = jumpTarget;
            default:   pcNext = pcPlus4;
        endcase
    end

    assign aluB = (ctrl.aluBSrc == B_IMM) ? immExt : rtValue;

    always_comb begin
        case (ctrl.regDstSel)
            DST_RD:  wbAddr = instr.rView.rd;
            DST_RA:  wbAddr = `RA_INDEX;
            default: wbAddr = instr.rView.rt;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:  wbValue = readData;   // sampled on the completing edge.
            WB_PC4:  wbValue = pcPlus4;
            default: wbValue = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc    <= `RESET_VECTOR;
            instr <= '0;               // decodes as a nop.
        end else if (!hold) begin
            if (ctrl.irLoad) begin
                instr <= readData;
            end
            if (ctrl.pcLoad) begin
                pc <= pcNext;
            end
        end
    end

    regFile regFile_inst (
        .clk       (clk),
        .arstN     (arstN),
        .readAddrA (instr.rView.rs),
        .readAddrB (instr.rView.rt),
        .writeAddr (wbAddr),
        .writeEn   (ctrl.regWrite && !hold),
        .writeData (wbValue),
        .readDataA (rsValue),
        .readDataB (rtValue),
        .regV0     (registerV0)
    );

    aluUnit aluUnit_inst (
        .opA    (rsValue),
        .opB    (aluB),
        .shamt  (instr.rView.shamt),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // effective address comes from the ALU for LW and SW.
    assign address    = ctrl.addrFromAlu ? aluResult : pc;
    assign writeData  = rtValue;
    assign byteEnable = `BYTE_ENABLE_ALL;

endmodule

// ==== source/mipsCpuBus.sv ====
`timescale 1ns/100ps

module mipsCpuBus import mipsPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    output logic       active,
    output word_t      registerV0,

    input  logic       waitRequest,
    input  word_t      readData,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writeData,
    output logic [3:0] byteEnable
);

    cpuState_e state;
    ctrl_t     ctrl;
    instr_t    instr;       // instruction register, decoded by the control unit.
    logic      aluZero;
    word_t     jumpTarget;  // checked against the halt address.

    controlUnit controlUnit_inst (
        .clk         (clk),
        .arstN       (arstN),
        .waitRequest (waitRequest),
        .instr       (instr),
        .aluZero     (aluZero),
        .jumpTarget  (jumpTarget),
        .state       (state),
        .ctrl        (ctrl),
        .read        (read),
        .write       (write),
        .active      (active)
    );

    dataPath dataPath_inst (
        .clk         (clk),
        .arstN       (arstN),
        .waitRequest (waitRequest),
        .readData    (readData),
        .state       (state),
        .ctrl        (ctrl),
        .instr       (instr),
        .aluZero     (aluZero),
        .jumpTarget  (jumpTarget),
        .registerV0  (registerV0),
        .address     (address),
        .writeData   (writeData),
        .byteEnable  (byteEnable)
    );

endmodule

// ==== source/mipsPkg.sv ====
package mipsPkg;

    typedef logic [31:0] word_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_e;

    // one instruction word, three ways of reading it.
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            funct_e     funct;
        } rView;
        struct packed {
            opcode_e     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } iView;
        struct packed {
            opcode_e     opcode;
            logic [25:0] target26;
        } jView;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } aluOp_e;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG} pcSel_e;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDst_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSel_e;
    typedef enum logic {B_REG, B_IMM} bSrc_e;

    typedef enum logic [1:0] {FETCH, EXEC1, EXEC2, HALTED} cpuState_e;

    typedef struct packed {
        logic    irLoad;
        logic    pcLoad;
        pcSel_e  pcSel;
        aluOp_e  aluOp;
        bSrc_e   aluBSrc;
        logic    extSigned;
        logic    regWrite;
        regDst_e regDstSel;
        wbSel_e  wbSel;
        logic    memRead;
        logic    memWrite;
        logic    addrFromAlu;
        logic    takeBranchEq;
        logic    takeBranchNe;
    } ctrl_t;

endpackage

// ==== source/regFile.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module regFile import mipsPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic [4:0] readAddrA,
    input  logic [4:0] readAddrB,
    input  logic [4:0] writeAddr,
    input  logic       writeEn,
    input  word_t      writeData,
    output word_t      readDataA,
    output word_t      readDataB,
    output word_t      regV0
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // $zero is hardwired.
    assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];
    assign regV0     = regs[2];

endmodule

// ==== verification/mipsCpuBusTb.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module mipsCpuBusTb import mipsPkg::*; ();

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 3;
    localparam int    PROG_LEN     = 60;
    localparam int    IDLE_CYCLES  = 10;
    localparam int    WATCHDOG_NS  = (PROG_LEN * (3 + 2 * 3) + 100) * CLK_PERIOD;
    localparam word_t DATA_BASE    = 32'h1000_0000;
    localparam int    DATA_WORDS   = 16;

    logic       clk;
    logic       arstN;
    logic       waitRequest;
    word_t      readData;
    logic       active;
    word_t      registerV0;
    word_t      address;
    logic       read;
    logic       write;
    word_t      writeData;
    logic [3:0] byteEnable;

    int unsigned lcgState = 25;
    word_t       mem [word_t];     // program and data, as seen by the bus.
    word_t       expFetch [$];
    word_t       expLoad [$];
    word_t       expStoreAddr [$];
    word_t       expStoreData [$];
    word_t       expV0;
    int          fetchIdx = 0;
    int          loadIdx = 0;
    int          storeIdx = 0;
    logic        busy = 1'b0;      // a transfer is being held off.
    int          stallLeft = 0;
    word_t       heldAddr;
    logic        heldWrite;
    logic        haltSeen = 1'b0;
    int          idleCount = 0;

    funct_e  rFuncts [9] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT, F_SLTU, F_SLL, F_SRL};
    opcode_e iOps [6]    = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};

    mipsCpuBus mipsCpuBus_inst (
        .clk         (clk),
        .arstN       (arstN),
        .active      (active),
        .registerV0  (registerV0),
        .waitRequest (waitRequest),
        .readData    (readData),
        .address     (address),
        .read        (read),
        .write       (write),
        .writeData   (writeData),
        .byteEnable  (byteEnable)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // low bits of the LCG repeat quickly.
    function automatic int unsigned pick(int unsigned n);
        return (nextRand() >> 8) % n;
    endfunction

    function automatic word_t addrOf(int idx);
        return `RESET_VECTOR + 32'(idx) * 32'd4;
    endfunction

    function automatic word_t fillWord(word_t a);
        return a ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t encR(funct_e f, logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                   logic [4:0] shamt);
        instr_t w;
        w.rView.opcode = OP_RTYPE;
        w.rView.rs     = rs;
        w.rView.rt     = rt;
        w.rView.rd     = rd;
        w.rView.shamt  = shamt;
        w.rView.funct  = f;
        return w;
    endfunction

    function automatic word_t encI(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                   logic [15:0] imm);
        instr_t w;
        w.iView.opcode = op;
        w.iView.rs     = rs;
        w.iView.rt     = rt;
        w.iView.imm16  = imm;
        return w;
    endfunction

    function automatic word_t encJ(opcode_e op, int idx);
        instr_t w;
        word_t  target;
        target          = addrOf(idx);
        w.jView.opcode   = op;
        w.jView.target26 = target[27:2];
        return w;
    endfunction

    // targets stay between idx + 1 and last + 1.
    function automatic word_t randomInstr(int idx, int last);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        funct_e      f;
        int unsigned span;
        rs   = 5'(pick(8));
        rt   = 5'(pick(8));
        rd   = 5'(1 + pick(7));
        span = 32'(last - idx + 1);
        case (pick(10))
            0, 1, 2: begin
                f = rFuncts[pick(9)];
                return encR(f, rs, rt, rd, (f == F_SLL || f == F_SRL) ? 5'(pick(32)) : 5'd0);
            end
            3, 4: return encI(iOps[pick(6)], rs, rd, 16'(nextRand() >> 16));
            5: return encI(OP_LUI, 5'd0, rd, 16'(nextRand() >> 16));
            6: return encI(OP_LW, 5'd28, rd, 16'(4 * pick(DATA_WORDS)));
            7: return encI(OP_SW, 5'd28, rt, 16'(4 * pick(DATA_WORDS)));
            8: begin
                if (pick(3) == 0) begin
                    rt = rs;    // equal operands, so BEQ gets taken too.
                end
                return encI((pick(2) == 0) ? OP_BEQ : OP_BNE, rs, rt, 16'(pick(span)));
            end
            default: return encJ(OP_J, idx + 1 + int'(pick(span)));
        endcase
    endfunction

    task automatic fillBody(int lo, int hi);
        int i;
        for (i = lo; i <= hi; i++) begin
            mem[addrOf(i)] = randomInstr(i, hi);
        end
    endtask

    // main body calls a subroutine, skips over it, then halts.
    task automatic buildProgram();
        int k;
        mem[addrOf(0)] = encI(OP_LUI, 5'd0, 5'd28, DATA_BASE[31:16]);
        mem[addrOf(1)] = encI(OP_ORI, 5'd28, 5'd28, DATA_BASE[15:0]);
        for (k = 1; k <= 7; k++) begin
            mem[addrOf(2 * k)]     = encI(OP_LUI, 5'd0, 5'(k), 16'(nextRand() >> 16));
            mem[addrOf(2 * k + 1)] = encI(OP_ORI, 5'(k), 5'(k), 16'(nextRand() >> 16));
        end
        fillBody(16, 26);
        mem[addrOf(27)] = encJ(OP_JAL, 39);
        fillBody(28, 37);
        mem[addrOf(38)] = encJ(OP_J, 50);
        fillBody(39, 48);
        mem[addrOf(49)] = encR(F_JR, 5'd31, 5'd0, 5'd0, 5'd0);
        fillBody(50, 58);
        mem[addrOf(59)] = encR(F_JR, 5'd0, 5'd0, 5'd0, 5'd0);
        for (k = 0; k < DATA_WORDS; k++) begin
            mem[DATA_BASE + 32'(4 * k)] = nextRand();
        end
    endtask

    // instruction level, no delay slots.
    task automatic runModel();
        word_t  regs [32];
        word_t  mm [word_t];
        word_t  pc;
        word_t  nextPc;
        word_t  a;
        word_t  b;
        word_t  simm;
        word_t  zimm;
        word_t  ea;
        word_t  tgt;
        instr_t ir;
        logic   halted;
        int     steps;
        int     r;
        mm = mem;
        for (r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc     = `RESET_VECTOR;
        halted = 1'b0;
        steps  = 0;
        while (!halted) begin
            expFetch.push_back(pc);
            ir     = mm.exists(pc) ? mm[pc] : fillWord(pc);
            a      = regs[ir.rView.rs];
            b      = regs[ir.rView.rt];
            simm   = {{16{ir.iView.imm16[15]}}, ir.iView.imm16};
            zimm   = {16'h0000, ir.iView.imm16};
            ea     = a + simm;
            nextPc = pc + 32'd4;
            tgt    = {nextPc[31:28], ir.jView.target26, 2'b00};
            case (ir.iView.opcode)
                OP_RTYPE: begin
                    case (ir.rView.funct)
                        F_ADDU: regs[ir.rView.rd] = a + b;
                        F_SUBU: regs[ir.rView.rd] = a - b;
                        F_AND:  regs[ir.rView.rd] = a & b;
                        F_OR:   regs[ir.rView.rd] = a | b;
                        F_XOR:  regs[ir.rView.rd] = a ^ b;
                        F_SLT:  regs[ir.rView.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLTU: regs[ir.rView.rd] = (a < b) ? 32'd1 : 32'd0;
                        F_SLL:  regs[ir.rView.rd] = b << ir.rView.shamt;
                        F_SRL:  regs[ir.rView.rd] = b >> ir.rView.shamt;
                        F_JR: begin
                            nextPc = a;
                            halted = (a == `HALT_ADDR);
                        end
                        default: ;
                    endcase
                end
                OP_ADDIU: regs[ir.iView.rt] = a + simm;
                OP_SLTI:  regs[ir.iView.rt] = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_SLTIU: regs[ir.iView.rt] = (a < simm) ? 32'd1 : 32'd0;
                OP_ANDI:  regs[ir.iView.rt] = a & zimm;
                OP_ORI:   regs[ir.iView.rt] = a | zimm;
                OP_XORI:  regs[ir.iView.rt] = a ^ zimm;
                OP_LUI:   regs[ir.iView.rt] = {ir.iView.imm16, 16'h0000};
                OP_LW: begin
                    expLoad.push_back(ea);
                    regs[ir.iView.rt] = mm.exists(ea) ? mm[ea] : fillWord(ea);
                end
                OP_SW: begin
                    expStoreAddr.push_back(ea);
                    expStoreData.push_back(b);
                    mm[ea] = b;
                end
                OP_BEQ: nextPc = (a == b) ? nextPc + (simm << 2) : nextPc;
                OP_BNE: nextPc = (a != b) ? nextPc + (simm << 2) : nextPc;
                OP_J, OP_JAL: begin
                    if (ir.iView.opcode == OP_JAL) begin
                        regs[31] = nextPc;
                    end
                    nextPc = tgt;
                    halted = (tgt == `HALT_ADDR);
                end
                default: ;
            endcase
            regs[0] = '0;
            pc      = nextPc;
            steps++;
            if (steps > 4 * PROG_LEN) begin
                stopRun("the reference model did not reach the halting jump");
            end
        end
        expV0 = regs[2];
    endtask

    task automatic stopRun(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            stopRun($sformatf("[FAIL] %0d ns: %s is %h, expected %h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkBit(logic actual, logic expected, string what);
        if (actual !== expected) begin
            stopRun($sformatf("[FAIL] %0d ns: %s is %b, expected %b",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkStore(word_t addr, word_t data, logic [3:0] be);
        if (storeIdx >= expStoreAddr.size()) begin
            stopRun("the CPU wrote to memory more often than the model did");
        end else begin
            checkWord(addr, expStoreAddr[storeIdx], "store address");
            checkWord(data, expStoreData[storeIdx], "store data");
            if (be !== 4'b1111) begin
                stopRun($sformatf("[FAIL] %0d ns: store byteEnable is %b, expected 1111",
                                  $time, be));
            end
            storeIdx++;
        end
    endtask

    // called on the falling edge before the completing rising edge.
    task automatic completeTransfer();
        if (write) begin
            checkStore(address, writeData, byteEnable);
            mem[address] = writeData;
        end else if (address >= `RESET_VECTOR && address < addrOf(PROG_LEN)) begin
            if (fetchIdx >= expFetch.size()) begin
                stopRun("the CPU fetched more instructions than the model executed");
            end else begin
                checkWord(address, expFetch[fetchIdx], "fetch address");
                fetchIdx++;
            end
        end else if (loadIdx >= expLoad.size()) begin
            stopRun("the CPU read data memory more often than the model did");
        end else begin
            checkWord(address, expLoad[loadIdx], "load address");
            loadIdx++;
        end
    endtask

    task automatic serviceBus();
        if (read && write) begin
            stopRun("read and write were high in the same cycle");
        end else if (!(read || write)) begin
            if (busy) begin
                stopRun("the CPU dropped its strobe before the transfer completed");
            end
            waitRequest = 1'b0;
        end else begin
            if (!busy) begin
                busy      = 1'b1;
                stallLeft = int'(pick(4));
                heldAddr  = address;
                heldWrite = write;
            end else if (address !== heldAddr || write !== heldWrite) begin
                stopRun("the bus address or direction changed during a stall");
            end
            if (stallLeft > 0) begin
                waitRequest = 1'b1;
                readData    = nextRand();    // junk until the transfer completes.
                stallLeft--;
            end else begin
                waitRequest = 1'b0;
                readData    = mem.exists(address) ? mem[address] : fillWord(address);
                busy        = 1'b0;
                completeTransfer();
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stopRun("timeout, the CPU did not halt in the expected number of cycles");
    end

    initial begin
        arstN       = 1'b0;
        waitRequest = 1'b0;
        readData    = '0;
        buildProgram();
        runModel();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkBit(read, 1'b0, "read during reset");
            checkBit(write, 1'b0, "write during reset");
            checkBit(active, 1'b1, "active during reset");
            checkWord(address, `RESET_VECTOR, "address during reset");
        end
        arstN       = 1'b1;
        waitRequest = 1'b1;    // first fetch is answered from the next falling edge.
        @(negedge clk);
        while (idleCount < IDLE_CYCLES) begin
            if (!active) begin
                if (!haltSeen) begin
                    haltSeen = 1'b1;
                    checkWord(word_t'(fetchIdx), word_t'(expFetch.size()), "fetch count at halt");
                    checkBit(busy, 1'b0, "transfer pending at halt");
                end
                if (read || write) begin
                    stopRun("the CPU accessed the bus after it halted");
                end
                waitRequest = 1'b0;
                idleCount++;
            end else begin
                serviceBus();
            end
            @(negedge clk);
        end
        checkWord(word_t'(storeIdx), word_t'(expStoreAddr.size()), "store count");
        checkWord(word_t'(loadIdx), word_t'(expLoad.size()), "load count");
        checkWord(registerV0, expV0, "register $2");
        $display("TEST PASSED");
        $finish;
    end

endmodule
